// ==== source/simd_data_pkg.sv ====
// ----------------------------------------
// datapath widths
// ----------------------------------------

package simd_data_pkg;

	// one source operand word from the core
	typedef logic [31:0] operand_t;

	// multiplier input of one cell
	// 16-bit halves plus sign and guard bit
	typedef logic signed [17:0] lane_operand_t;

	// running sum of one cell
	// 36-bit product with 12 bits of headroom
	typedef logic signed [47:0] lane_acc_t;

	// packed result word
	//   byte mode: four 16-bit fields
	//   half mode: two 32-bit fields
	//   word mode: full 64-bit product
	typedef logic [63:0] result_t;

endpackage

// ==== source/simd_op_pkg.sv ====
// ----------------------------------------
// operation encoding
// ----------------------------------------

package simd_op_pkg;

	// lane layout select
	typedef logic [1:0] simd_mode_t;

	// mode codes, same as the core's size field
	localparam simd_mode_t MODE_BYTE     = 2'd0;
	localparam simd_mode_t MODE_HALF     = 2'd1;
	// reserved code, result forced to zero
	localparam simd_mode_t MODE_RESERVED = 2'd2;
	localparam simd_mode_t MODE_WORD     = 2'd3;

	// number of 18x18 cells
	localparam int LANE_COUNT = 4;

	// in_valid to out_valid
	// 3 split + 2 mac + 2 combine
	localparam int SIMD_LATENCY = 7;

endpackage

// ==== source/simd_operand_split.sv ====
module simd_operand_split (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        in_valid,
	input  logic                        in_signed,
	input  simd_op_pkg::simd_mode_t     in_mode,
	input  logic                        in_accumulate,
	input  simd_data_pkg::operand_t     in_data0,
	input  simd_data_pkg::operand_t     in_data1,
	output logic                        lane_valid,
	output simd_op_pkg::simd_mode_t     lane_mode,
	output logic                        lane_accumulate,
	output simd_data_pkg::lane_operand_t lane0_a,
	output simd_data_pkg::lane_operand_t lane1_a,
	output simd_data_pkg::lane_operand_t lane2_a,
	output simd_data_pkg::lane_operand_t lane3_a,
	output simd_data_pkg::lane_operand_t lane0_b,
	output simd_data_pkg::lane_operand_t lane1_b,
	output simd_data_pkg::lane_operand_t lane2_b,
	output simd_data_pkg::lane_operand_t lane3_b
);

	// byte to 18 bits, sign or zero fill
	function automatic simd_data_pkg::lane_operand_t extend_byte(input logic [7:0] value,
			input logic sign_ext);
		extend_byte = {{10{sign_ext & value[7]}}, value};
	endfunction

	// halfword to 18 bits, sign or zero fill
	function automatic simd_data_pkg::lane_operand_t extend_half(input logic [15:0] value,
			input logic sign_ext);
		extend_half = {{2{sign_ext & value[15]}}, value};
	endfunction

	// ----------------------------------------
	// stage 1: input register
	// ----------------------------------------
	logic                    in_valid_q;
	logic                    in_signed_q;
	logic                    in_accumulate_q;
	simd_op_pkg::simd_mode_t in_mode_q;
	simd_data_pkg::operand_t in_a_q;
	simd_data_pkg::operand_t in_b_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_valid_q <= 1'b0;
		end else begin
			in_valid_q <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		in_signed_q     <= in_signed;
		in_accumulate_q <= in_accumulate;
		in_mode_q       <= in_mode;
		in_a_q          <= in_data0;
		in_b_q          <= in_data1;
	end

	// ----------------------------------------
	// stage 2: byte and half extension
	// ----------------------------------------
	logic                         ext_valid;
	logic                         ext_accumulate;
	simd_op_pkg::simd_mode_t      ext_mode;
	simd_data_pkg::lane_operand_t byte_a [simd_op_pkg::LANE_COUNT];
	simd_data_pkg::lane_operand_t byte_b [simd_op_pkg::LANE_COUNT];
	simd_data_pkg::lane_operand_t half_a [2];
	simd_data_pkg::lane_operand_t half_b [2];

	always_ff @(posedge clk) begin
		if (reset) begin
			ext_valid <= 1'b0;
		end else begin
			ext_valid <= in_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		ext_accumulate <= in_accumulate_q;
		ext_mode       <= in_mode_q;
		// byte i of each operand feeds cell i
		for (int i = 0; i < simd_op_pkg::LANE_COUNT; i++) begin
			byte_a[i] <= extend_byte(in_a_q[8*i +: 8], in_signed_q);
			byte_b[i] <= extend_byte(in_b_q[8*i +: 8], in_signed_q);
		end
		for (int i = 0; i < 2; i++) begin
			half_a[i] <= extend_half(in_a_q[16*i +: 16], in_signed_q);
			half_b[i] <= extend_half(in_b_q[16*i +: 16], in_signed_q);
		end
	end

	// ----------------------------------------
	// stage 3: route to the four cells
	// ----------------------------------------

	// idle slots send zero with accumulate set, so each cell keeps its sum;
	// during reset accumulate is low and the cells load zero
	always_ff @(posedge clk) begin
		if (reset) begin
			lane_valid      <= 1'b0;
			lane_accumulate <= 1'b0;
		end else begin
			lane_valid      <= ext_valid;
			lane_accumulate <= ext_valid ? ext_accumulate : 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		lane_mode <= ext_mode;
		// zeros unless a mode below fills the cell
		lane0_a <= '0;
		lane1_a <= '0;
		lane2_a <= '0;
		lane3_a <= '0;
		lane0_b <= '0;
		lane1_b <= '0;
		lane2_b <= '0;
		lane3_b <= '0;
		if (ext_valid) begin
			case (ext_mode)
				simd_op_pkg::MODE_BYTE: begin
					lane0_a <= byte_a[0];
					lane0_b <= byte_b[0];
					lane1_a <= byte_a[1];
					lane1_b <= byte_b[1];
					lane2_a <= byte_a[2];
					lane2_b <= byte_b[2];
					lane3_a <= byte_a[3];
					lane3_b <= byte_b[3];
				end
				simd_op_pkg::MODE_HALF: begin
					// cells 2 and 3 stay at zero
					lane0_a <= half_a[0];
					lane0_b <= half_b[0];
					lane1_a <= half_a[1];
					lane1_b <= half_b[1];
				end
				simd_op_pkg::MODE_WORD: begin
					// low halves always unsigned, high halves per in_signed
					lane0_a <= {2'b00, half_a[0][15:0]};
					lane0_b <= {2'b00, half_b[0][15:0]};
					lane1_a <= half_a[1];
					lane1_b <= {2'b00, half_b[0][15:0]};
					lane2_a <= {2'b00, half_a[0][15:0]};
					lane2_b <= half_b[1];
					lane3_a <= half_a[1];
					lane3_b <= half_b[1];
				end
				default: begin
					// reserved, all cells get zero
				end
			endcase
		end
	end

endmodule

// ==== source/mac18x18.sv ====
module mac18x18 (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         accumulate,
	input  simd_data_pkg::lane_operand_t operand_a,
	input  simd_data_pkg::lane_operand_t operand_b,
	output simd_data_pkg::lane_acc_t     acc
);

	// ----------------------------------------
	// stage 1: product register
	// ----------------------------------------
	logic               accumulate_q;
	logic signed [35:0] product_q;

	// accumulate flag travels with its product
	always_ff @(posedge clk) begin
		if (reset) begin
			accumulate_q <= 1'b0;
		end else begin
			accumulate_q <= accumulate;
		end
	end

	// full signed 18x18 product
	always_ff @(posedge clk) begin
		product_q <= operand_a * operand_b;
	end

	// ----------------------------------------
	// stage 2: accumulator
	// ----------------------------------------
	simd_data_pkg::lane_acc_t product_ext;

	// sign extend into the accumulator width
	assign product_ext = {{12{product_q[35]}}, product_q};

	// load on a fresh op, add on accumulate
	// wraps at 48 bits, no saturation
	always_ff @(posedge clk) begin
		if (accumulate_q) begin
			acc <= acc + product_ext;
		end else begin
			acc <= product_ext;
		end
	end

endmodule

// ==== source/simd_result_combine.sv ====
module simd_result_combine (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     lane_valid,
	input  simd_op_pkg::simd_mode_t  lane_mode,
	input  simd_data_pkg::lane_acc_t acc0,
	input  simd_data_pkg::lane_acc_t acc1,
	input  simd_data_pkg::lane_acc_t acc2,
	input  simd_data_pkg::lane_acc_t acc3,
	output logic                     out_valid,
	output simd_data_pkg::result_t   out_data
);

	// sign extend a lane sum to the result width
	function automatic simd_data_pkg::result_t widen(input simd_data_pkg::lane_acc_t value);
		widen = {{16{value[47]}}, value};
	endfunction

	// ----------------------------------------
	// align control with the cell outputs
	// ----------------------------------------
	logic                    valid_d1;
	logic                    valid_d2;
	simd_op_pkg::simd_mode_t mode_d1;
	simd_op_pkg::simd_mode_t mode_d2;

	// two cycles, product register plus accumulator
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end else begin
			valid_d1 <= lane_valid;
			valid_d2 <= valid_d1;
		end
	end

	always_ff @(posedge clk) begin
		mode_d1 <= lane_mode;
		mode_d2 <= mode_d1;
	end

	// ----------------------------------------
	// stage 1: packing and partial shifts
	// ----------------------------------------
	logic                   part_valid;
	simd_data_pkg::result_t part_lo;
	simd_data_pkg::result_t part_hi;

	always_ff @(posedge clk) begin
		if (reset) begin
			part_valid <= 1'b0;
		end else begin
			part_valid <= valid_d2;
		end
	end

	// packed modes leave part_hi at zero
	always_ff @(posedge clk) begin
		part_lo <= '0;
		part_hi <= '0;
		case (mode_d2)
			simd_op_pkg::MODE_BYTE: begin
				// lane 0 in the lowest field
				part_lo <= {acc3[15:0], acc2[15:0], acc1[15:0], acc0[15:0]};
			end
			simd_op_pkg::MODE_HALF: begin
				part_lo <= {acc1[31:0], acc0[31:0]};
			end
			simd_op_pkg::MODE_WORD: begin
				// ll + (hl << 16) and (lh << 16) + (hh << 32)
				part_lo <= widen(acc0) + (widen(acc1) << 16);
				part_hi <= (widen(acc2) << 16) + (widen(acc3) << 32);
			end
			default: begin
				// reserved, both parts zero
			end
		endcase
	end

	// ----------------------------------------
	// stage 2: final sum
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= part_valid;
		end
	end

	// truncated to 64 bits
	always_ff @(posedge clk) begin
		out_data <= part_lo + part_hi;
	end

endmodule

// ==== source/simd_mul.sv ====
module simd_mul (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    in_valid,
	input  logic                    in_signed,
	input  simd_op_pkg::simd_mode_t in_mode,
	input  logic                    in_accumulate,
	input  simd_data_pkg::operand_t in_data0,
	input  simd_data_pkg::operand_t in_data1,
	output logic                    out_valid,
	output simd_data_pkg::result_t  out_data
);

	// ----------------------------------------
	// splitter to cells
	// ----------------------------------------
	logic                         lane_valid;
	logic                         lane_accumulate;
	simd_op_pkg::simd_mode_t      lane_mode;
	simd_data_pkg::lane_operand_t lane0_a;
	simd_data_pkg::lane_operand_t lane1_a;
	simd_data_pkg::lane_operand_t lane2_a;
	simd_data_pkg::lane_operand_t lane3_a;
	simd_data_pkg::lane_operand_t lane0_b;
	simd_data_pkg::lane_operand_t lane1_b;
	simd_data_pkg::lane_operand_t lane2_b;
	simd_data_pkg::lane_operand_t lane3_b;

	// cells to combiner
	simd_data_pkg::lane_acc_t acc0;
	simd_data_pkg::lane_acc_t acc1;
	simd_data_pkg::lane_acc_t acc2;
	simd_data_pkg::lane_acc_t acc3;

	// 3 cycles
	simd_operand_split split_i (
		.clk             (clk),
		.reset           (reset),
		.in_valid        (in_valid),
		.in_signed       (in_signed),
		.in_mode         (in_mode),
		.in_accumulate   (in_accumulate),
		.in_data0        (in_data0),
		.in_data1        (in_data1),
		.lane_valid      (lane_valid),
		.lane_mode       (lane_mode),
		.lane_accumulate (lane_accumulate),
		.lane0_a         (lane0_a),
		.lane1_a         (lane1_a),
		.lane2_a         (lane2_a),
		.lane3_a         (lane3_a),
		.lane0_b         (lane0_b),
		.lane1_b         (lane1_b),
		.lane2_b         (lane2_b),
		.lane3_b         (lane3_b)
	);

	// 2 cycles each, all four in step
	mac18x18 mac_lane0 (
		.clk        (clk),
		.reset      (reset),
		.accumulate (lane_accumulate),
		.operand_a  (lane0_a),
		.operand_b  (lane0_b),
		.acc        (acc0)
	);

	mac18x18 mac_lane1 (
		.clk        (clk),
		.reset      (reset),
		.accumulate (lane_accumulate),
		.operand_a  (lane1_a),
		.operand_b  (lane1_b),
		.acc        (acc1)
	);

	mac18x18 mac_lane2 (
		.clk        (clk),
		.reset      (reset),
		.accumulate (lane_accumulate),
		.operand_a  (lane2_a),
		.operand_b  (lane2_b),
		.acc        (acc2)
	);

	mac18x18 mac_lane3 (
		.clk        (clk),
		.reset      (reset),
		.accumulate (lane_accumulate),
		.operand_a  (lane3_a),
		.operand_b  (lane3_b),
		.acc        (acc3)
	);

	// 2 cycles after the cells, delays valid and mode itself
	simd_result_combine combine_i (
		.clk        (clk),
		.reset      (reset),
		.lane_valid (lane_valid),
		.lane_mode  (lane_mode),
		.acc0       (acc0),
		.acc1       (acc1),
		.acc2       (acc2),
		.acc3       (acc3),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

// ==== tests/simd_mul_assertions.sv ====
module simd_mul_assertions (
	input logic                    clk,
	input logic                    reset,
	input logic                    in_valid,
	input simd_op_pkg::simd_mode_t in_mode,
	input logic                    out_valid,
	input simd_data_pkg::result_t  out_data
);
	timeunit 1ns;
	timeprecision 1ps;

	// strobes in flight, one bit per pipeline cycle
	logic [simd_op_pkg::SIMD_LATENCY-1:0] in_flight;

	always_ff @(posedge clk) begin
		if (reset) begin
			in_flight <= '0;
		end else begin
			in_flight <= {in_flight[simd_op_pkg::SIMD_LATENCY-2:0], in_valid};
		end
	end

	// low during reset and on the first cycle after it
	valid_low_in_reset: assert property (@(posedge clk) $past(reset) |-> !out_valid)
		else $error("out_valid high during or right after reset");

	// one result per strobe, fixed latency
	valid_latency: assert property (@(posedge clk) disable iff (reset)
		out_valid == in_flight[simd_op_pkg::SIMD_LATENCY-1])
		else $error("out_valid does not follow in_valid by the pipeline latency");

	// reserved code gives zero
	reserved_zero: assert property (@(posedge clk) disable iff (reset)
		(out_valid && ($past(in_mode, simd_op_pkg::SIMD_LATENCY) == simd_op_pkg::MODE_RESERVED))
		|-> out_data == '0)
		else $error("reserved mode result is not zero");

endmodule

bind simd_mul simd_mul_assertions simd_mul_assertions_i (
	.clk       (clk),
	.reset     (reset),
	.in_valid  (in_valid),
	.in_mode   (in_mode),
	.out_valid (out_valid),
	.out_data  (out_data)
);

// ==== tests/simd_mul_tb.sv ====
module simd_mul_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    in_valid;
	logic                    in_signed;
	simd_op_pkg::simd_mode_t in_mode;
	logic                    in_accumulate;
	simd_data_pkg::operand_t in_data0;
	simd_data_pkg::operand_t in_data1;
	logic                    out_valid;
	simd_data_pkg::result_t  out_data;

	// expected results and issue cycles in order
	simd_data_pkg::result_t expected_q[$];
	int                     issue_q[$];
	int                     cycle = 0;
	int                     in_count = 0;
	int                     out_count = 0;
	logic                   reset_held = 1'b0;

	// mirror of the lane sums
	// lane 0 holds the whole sum in word mode
	logic [63:0] lane_sum [simd_op_pkg::LANE_COUNT];

	// mode and signedness an accumulate must repeat
	simd_op_pkg::simd_mode_t chain_mode;
	logic                    chain_signed;
	logic                    chain_open = 1'b0;
	logic [31:0]             lcg_state = 32'd53669;

	simd_mul simd_mul_i (
		.clk           (clk),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_signed     (in_signed),
		.in_mode       (in_mode),
		.in_accumulate (in_accumulate),
		.in_data0      (in_data0),
		.in_data1      (in_data1),
		.out_valid     (out_valid),
		.out_data      (out_data)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// ----------------------------------------
	// random numbers and reference model
	// ----------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// mostly random with the odd corner value
	function automatic simd_data_pkg::operand_t pick_operand();
		logic [31:0] r;
		r = lcg_next();
		case (r[31:29])
			3'd0: return 32'hffffffff;
			3'd1: return 32'h80000000;
			3'd2: return 32'h80008080;
			3'd3: return 32'h7fff7f7f;
			default: return lcg_next();
		endcase
	endfunction

	// low width bits of a value sign or zero filled to 64 bits
	function automatic logic [63:0] extend_field(input logic [31:0] value, input int width,
			input logic sgn);
		logic [63:0] mask;
		logic [63:0] field;
		mask = (64'd1 << width) - 64'd1;
		field = {32'd0, value} & mask;
		if (sgn && value[width-1]) begin
			field = field | ~mask;
		end
		return field;
	endfunction

	// per-lane product, running sum, then packing by mode
	function automatic simd_data_pkg::result_t reference_result(
			input simd_op_pkg::simd_mode_t mode, input logic sgn, input logic acc,
			input simd_data_pkg::operand_t a, input simd_data_pkg::operand_t b);
		simd_data_pkg::result_t res;
		logic [63:0]            prod;
		int                     width;
		int                     lanes;
		res = '0;
		case (mode)
			simd_op_pkg::MODE_BYTE: begin
				width = 8;
				lanes = 4;
			end
			simd_op_pkg::MODE_HALF: begin
				width = 16;
				lanes = 2;
			end
			simd_op_pkg::MODE_WORD: begin
				width = 32;
				lanes = 1;
			end
			default: begin
				width = 0;
				lanes = 0;
			end
		endcase
		// reserved without accumulate loads zero into every cell
		if (lanes == 0 && !acc) begin
			for (int i = 0; i < simd_op_pkg::LANE_COUNT; i++) begin
				lane_sum[i] = '0;
			end
		end
		for (int i = 0; i < lanes; i++) begin
			prod = extend_field(a >> (width * i), width, sgn)
				* extend_field(b >> (width * i), width, sgn);
			lane_sum[i] = acc ? lane_sum[i] + prod : prod;
			case (mode)
				simd_op_pkg::MODE_BYTE: res[16*i +: 16] = lane_sum[i][15:0];
				simd_op_pkg::MODE_HALF: res[32*i +: 32] = lane_sum[i][31:0];
				default: res = lane_sum[0];
			endcase
		end
		return res;
	endfunction

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic stop_run(input string reason);
		$display("*** FAILED ***");
		$fatal(1, "%s", reason);
	endtask

	task automatic compare_result(input simd_data_pkg::result_t got,
			input simd_data_pkg::result_t expected, input string name);
		if (got !== expected) begin
			$display("Fail time=%0t signal=%s got=%h expected=%h", $time, name, got, expected);
			stop_run("wrong result value");
		end
	endtask

	task automatic compare_count(input int got, input int expected, input string name);
		if (got != expected) begin
			$display("Fail time=%0t signal=%s got=%0d expected=%0d", $time, name, got, expected);
			stop_run("wrong count");
		end
	endtask

	// capture each strobe at the falling edge
	always @(negedge clk) begin
		if (!reset && in_valid) begin
			expected_q.push_back(reference_result(in_mode, in_signed, in_accumulate,
				in_data0, in_data1));
			issue_q.push_back(cycle);
		end
	end

	always @(negedge clk) begin : compare_proc
		simd_data_pkg::result_t expected;
		int                     issued;
		if (reset) begin
			// pipeline must be empty after the first reset edge
			if (reset_held && out_valid !== 1'b0) begin
				stop_run("out_valid not low during reset");
			end
			reset_held = 1'b1;
			expected_q.delete();
			issue_q.delete();
			in_count = out_count;
		end else begin
			reset_held = 1'b0;
			if (out_valid === 1'b1) begin
				if (expected_q.size() == 0) begin
					stop_run("out_valid with no operation in flight");
				end
				expected = expected_q.pop_front();
				issued = issue_q.pop_front();
				compare_result(out_data, expected, "out_data");
				compare_count(cycle - issued, simd_op_pkg::SIMD_LATENCY, "out_valid latency");
				out_count++;
			end else if (out_valid !== 1'b0) begin
				stop_run("out_valid is unknown");
			end
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic send_op(input simd_op_pkg::simd_mode_t mode, input logic sgn,
			input logic acc);
		@(posedge clk);
		in_valid      <= 1'b1;
		in_mode       <= mode;
		in_signed     <= sgn;
		in_accumulate <= acc;
		in_data0      <= pick_operand();
		in_data1      <= pick_operand();
		in_count++;
		chain_mode   = mode;
		chain_signed = sgn;
		chain_open   = (mode != simd_op_pkg::MODE_RESERVED);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid      <= 1'b0;
			in_accumulate <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expected_q.size() != 0) begin
			@(posedge clk);
			waited++;
			if (waited > 4 * simd_op_pkg::SIMD_LATENCY) begin
				stop_run("results did not arrive in time");
			end
		end
	endtask

	initial begin
		logic [31:0]             r;
		simd_op_pkg::simd_mode_t m;
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_signed     = 1'b0;
		in_mode       = simd_op_pkg::MODE_BYTE;
		in_accumulate = 1'b0;
		in_data0      = '0;
		in_data1      = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		idle_cycles(2);

		// plain products in every mode and signedness back to back
		for (int s = 0; s < 2; s++) begin
			for (int k = 0; k < 4; k++) begin
				m = simd_op_pkg::simd_mode_t'(k);
				repeat (6) send_op(m, s[0], 1'b0);
			end
		end
		idle_cycles(3);

		// accumulate runs with one idle gap inside each
		for (int s = 0; s < 2; s++) begin
			for (int k = 0; k < 4; k++) begin
				m = simd_op_pkg::simd_mode_t'(k);
				if (m != simd_op_pkg::MODE_RESERVED) begin
					send_op(m, s[0], 1'b0);
					repeat (6) send_op(m, s[0], 1'b1);
					idle_cycles(1);
					repeat (6) send_op(m, s[0], 1'b1);
				end
			end
		end

		// random mix of modes, chains and gaps
		repeat (250) begin
			r = lcg_next();
			if (chain_open && r[2:0] < 3'd5) begin
				send_op(chain_mode, chain_signed, 1'b1);
			end else begin
				send_op(simd_op_pkg::simd_mode_t'(r[5:4]), r[6], 1'b0);
			end
			if (r[10:8] == 3'd0) begin
				idle_cycles(int'(r[12:11]) + 1);
			end
		end

		// reset with operations still in flight
		repeat (4) send_op(simd_op_pkg::MODE_WORD, 1'b1, 1'b0);
		@(posedge clk);
		in_valid <= 1'b0;
		reset    <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		chain_open = 1'b0;
		idle_cycles(2);
		repeat (5) send_op(simd_op_pkg::MODE_HALF, 1'b1, 1'b0);
		idle_cycles(1);

		wait_drain();
		// no stray strobes after the last result
		idle_cycles(simd_op_pkg::SIMD_LATENCY + 2);
		compare_count(out_count, in_count, "result count");
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== simd_mul.f ====
source/simd_data_pkg.sv
source/simd_op_pkg.sv
source/simd_operand_split.sv
source/mac18x18.sv
source/simd_result_combine.sv
source/simd_mul.sv
tests/simd_mul_assertions.sv
tests/simd_mul_tb.sv

// ==== Makefile ====
# Verilator build and run for the SIMD multiply-accumulate testbench

VERILATOR ?= verilator
TOP       ?= simd_mul_tb
FILELIST  ?= simd_mul.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: simulate clean

# build, then run; a $fatal in the testbench gives a failing exit status
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
